// File: rtl/mem_sys_pkg.sv
// Shared widths and encodings for the data-cache memory system
// Holds the controller state and host opcode enums
package mem_sys_pkg;

	// Word side
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// Cache geometry of 256 lines of 64 bytes
	localparam int line_w = 512;
	localparam int index_w = 8;
	localparam int offset_w = 6;
	localparam int tag_w = addr_w - index_w - offset_w;

	// Request to the host memory controller
	typedef enum logic [1:0] {
		op_none = 2'd0,
		op_read = 2'd1,
		op_write = 2'd2
	} host_op_t;

	// Cache controller states
	typedef enum logic [2:0] {
		st_init,
		st_idle,
		st_lookup,
		st_wb_req,
		st_wb_wait,
		st_fill_req,
		st_fill_wait,
		st_finish
	} ctrl_state_t;

endpackage

// File: rtl/init_sweep.sv
// Startup invalidation sweep
// Walks every cache index once after reset, then flags completion
`timescale 1ns/1ps

module init_sweep #(
	parameter int index_w = mem_sys_pkg::index_w
) (
	input logic clk,
	input logic reset,
	output logic [index_w-1:0] clear_index,
	output logic clear,
	output logic sweep_done
);

	logic [index_w-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			sweep_done <= 1'b0;
		end else if (!sweep_done) begin
			count <= count + 1'b1;
			// Last line cleared this cycle
			if (&count) begin
				sweep_done <= 1'b1;
			end
		end
	end

	// One index cleared per cycle until the walk ends
	assign clear = ~sweep_done;
	assign clear_index = count;

endmodule

// File: rtl/tag_store.sv
// Tag store for the direct-mapped cache
// Valid, dirty and tag arrays with the hit compare on the current index
`timescale 1ns/1ps

module tag_store #(
	parameter int index_w = mem_sys_pkg::index_w,
	localparam int tag_w = mem_sys_pkg::addr_w - index_w - mem_sys_pkg::offset_w
) (
	input logic clk,
	input logic [index_w-1:0] index,
	input logic [tag_w-1:0] tag,
	input logic clear,
	input logic [index_w-1:0] clear_index,
	input logic word_wr,
	input logic fill,
	output logic hit,
	output logic dirty,
	output logic [tag_w-1:0] victim_tag
);

	localparam int lines = 1 << index_w;

	logic [lines-1:0] valid;
	logic [lines-1:0] dirty_bits;
	logic [tag_w-1:0] tag_mem [lines];

	// State bits are wiped by the startup sweep
	always_ff @(posedge clk) begin
		if (clear) begin
			valid[clear_index] <= 1'b0;
			dirty_bits[clear_index] <= 1'b0;
		end else if (fill) begin
			valid[index] <= 1'b1;
			dirty_bits[index] <= 1'b0;
		end else if (word_wr) begin
			dirty_bits[index] <= 1'b1;
		end
	end

	// New tag arrives with the line fill
	always_ff @(posedge clk) begin
		if (fill) begin
			tag_mem[index] <= tag;
		end
	end

	assign hit = valid[index] && (tag_mem[index] == tag);
	assign dirty = dirty_bits[index];
	assign victim_tag = tag_mem[index];

endmodule

// File: rtl/line_store.sv
// Line data array for the direct-mapped cache
// Whole-line fill, single-word merge and combinational word select
`timescale 1ns/1ps

module line_store #(
	parameter int index_w = mem_sys_pkg::index_w,
	parameter int line_w = mem_sys_pkg::line_w,
	localparam int sel_w = $clog2(line_w / mem_sys_pkg::data_w)
) (
	input logic clk,
	input logic [index_w-1:0] index,
	input logic [sel_w-1:0] word_sel,
	input logic word_wr,
	input logic [mem_sys_pkg::data_w-1:0] word_data,
	input logic fill,
	input logic [line_w-1:0] fill_line,
	output logic [line_w-1:0] line_out,
	output logic [mem_sys_pkg::data_w-1:0] word_out
);

	import mem_sys_pkg::*;

	localparam int lines = 1 << index_w;

	logic [line_w-1:0] mem [lines];

	always_ff @(posedge clk) begin
		if (fill) begin
			mem[index] <= fill_line;
		end else if (word_wr) begin
			// Merge one word and leave the rest of the line untouched
			mem[index][word_sel*data_w +: data_w] <= word_data;
		end
	end

	assign line_out = mem[index];
	assign word_out = line_out[word_sel*data_w +: data_w];

endmodule

// File: rtl/cache_ctrl.sv
// Cache controller FSM
// Sequences lookups, dirty write-backs and line fills for one access at a time
`timescale 1ns/1ps

module cache_ctrl #(
	parameter int index_w = mem_sys_pkg::index_w,
	parameter int line_w = mem_sys_pkg::line_w,
	localparam int tag_w = mem_sys_pkg::addr_w - index_w - mem_sys_pkg::offset_w,
	localparam int sel_w = $clog2(line_w / mem_sys_pkg::data_w)
) (
	input logic clk,
	input logic reset,
	input logic en,
	input logic wr,
	input logic [mem_sys_pkg::addr_w-1:0] addr,
	input logic [mem_sys_pkg::data_w-1:0] data_in,
	input logic sweep_done,
	input logic hit,
	input logic dirty,
	input logic [tag_w-1:0] victim_tag,
	input logic [line_w-1:0] line_out,
	input logic [mem_sys_pkg::data_w-1:0] word_out,
	input logic [line_w-1:0] data_in_host,
	input logic tx_done_host,
	input logic rd_valid_host,
	output logic done,
	output logic data_valid,
	output logic cache_hit,
	output logic [mem_sys_pkg::data_w-1:0] data_out,
	output logic [index_w-1:0] index,
	output logic [tag_w-1:0] tag,
	output logic [sel_w-1:0] word_sel,
	output logic word_wr,
	output logic [mem_sys_pkg::data_w-1:0] word_data,
	output logic fill,
	output logic [line_w-1:0] fill_line,
	output mem_sys_pkg::host_op_t op_host,
	output logic [mem_sys_pkg::addr_w-1:0] addr_out_host,
	output logic [line_w-1:0] data_out_host
);

	import mem_sys_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	// Accepted request
	logic req_wr;
	logic [addr_w-1:0] req_addr;
	logic [data_w-1:0] req_data;

	// Set by the line fill so the next lookup is the replay
	logic refill;

	logic accept;

	assign accept = (state == st_idle) && en;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_init;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_init: begin
				if (sweep_done) begin
					state_next = st_idle;
				end
			end
			st_idle: begin
				if (en) begin
					state_next = st_lookup;
				end
			end
			st_lookup: begin
				if (hit) begin
					state_next = st_finish;
				end else if (dirty) begin
					state_next = st_wb_req;
				end else begin
					state_next = st_fill_req;
				end
			end
			// Hold the host write until the host acknowledges it
			st_wb_req, st_wb_wait: begin
				state_next = tx_done_host ? st_fill_req : st_wb_wait;
			end
			st_fill_req, st_fill_wait: begin
				state_next = rd_valid_host ? st_lookup : st_fill_wait;
			end
			st_finish: state_next = st_idle;
			default: state_next = st_init;
		endcase
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_wr <= wr;
			req_addr <= addr;
			req_data <= data_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			refill <= 1'b0;
			cache_hit <= 1'b0;
		end else begin
			if (accept) begin
				refill <= 1'b0;
			end else if (fill) begin
				refill <= 1'b1;
			end
			// Only the first lookup of an access counts
			if (state == st_lookup && !refill) begin
				cache_hit <= hit;
			end
		end
	end

	// Writes return the new word
	always_ff @(posedge clk) begin
		if (state == st_lookup && hit) begin
			data_out <= req_wr ? req_data : word_out;
		end
	end

	assign done = (state == st_idle);
	assign data_valid = (state == st_finish);

	// Store addressing from the registered request
	assign tag = req_addr[addr_w-1 -: tag_w];
	assign index = req_addr[offset_w +: index_w];
	assign word_sel = req_addr[2 +: sel_w];

	assign word_wr = (state == st_lookup) && hit && req_wr;
	assign word_data = req_data;
	assign fill = ((state == st_fill_req) || (state == st_fill_wait)) && rd_valid_host;
	assign fill_line = data_in_host;

	always_comb begin
		case (state)
			st_wb_req, st_wb_wait: op_host = op_write;
			st_fill_req, st_fill_wait: op_host = op_read;
			default: op_host = op_none;
		endcase
	end

	// Victim goes back at its own tag and fills use the request tag
	always_comb begin
		if (state == st_wb_req || state == st_wb_wait) begin
			addr_out_host = {victim_tag, index, {offset_w{1'b0}}};
		end else begin
			addr_out_host = {tag, index, {offset_w{1'b0}}};
		end
	end

	assign data_out_host = line_out;

endmodule

// File: rtl/mem_system.sv
// Data-cache memory system top level
// Direct-mapped write-back cache between a word port and a line-wide host port
`timescale 1ns/1ps

module mem_system #(
	parameter int index_w = mem_sys_pkg::index_w,
	parameter int line_w = mem_sys_pkg::line_w
) (
	input logic clk,
	input logic reset,
	input logic en,
	input logic wr,
	input logic [mem_sys_pkg::addr_w-1:0] addr,
	input logic [mem_sys_pkg::data_w-1:0] data_in,
	output logic [mem_sys_pkg::data_w-1:0] data_out,
	output logic data_valid,
	output logic done,
	// Host memory controller
	input logic [line_w-1:0] data_in_host,
	input logic tx_done_host,
	input logic rd_valid_host,
	output logic [line_w-1:0] data_out_host,
	output logic [mem_sys_pkg::addr_w-1:0] addr_out_host,
	output mem_sys_pkg::host_op_t op_host,
	// Hit statistic for the access just completed
	output logic cache_hit
);

	import mem_sys_pkg::*;

	localparam int tag_w = addr_w - index_w - offset_w;
	localparam int sel_w = $clog2(line_w / data_w);

	// Store controls from the FSM
	logic [index_w-1:0] index;
	logic [tag_w-1:0] tag;
	logic [sel_w-1:0] word_sel;
	logic word_wr;
	logic [data_w-1:0] word_data;
	logic fill;
	logic [line_w-1:0] fill_line;

	// Store results
	logic hit;
	logic dirty;
	logic [tag_w-1:0] victim_tag;
	logic [line_w-1:0] line_out;
	logic [data_w-1:0] word_out;

	// Startup sweep
	logic [index_w-1:0] clear_index;
	logic clear;
	logic sweep_done;

	cache_ctrl #(
		.index_w(index_w),
		.line_w(line_w)
	) cache_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.en(en),
		.wr(wr),
		.addr(addr),
		.data_in(data_in),
		.sweep_done(sweep_done),
		.hit(hit),
		.dirty(dirty),
		.victim_tag(victim_tag),
		.line_out(line_out),
		.word_out(word_out),
		.data_in_host(data_in_host),
		.tx_done_host(tx_done_host),
		.rd_valid_host(rd_valid_host),
		.done(done),
		.data_valid(data_valid),
		.cache_hit(cache_hit),
		.data_out(data_out),
		.index(index),
		.tag(tag),
		.word_sel(word_sel),
		.word_wr(word_wr),
		.word_data(word_data),
		.fill(fill),
		.fill_line(fill_line),
		.op_host(op_host),
		.addr_out_host(addr_out_host),
		.data_out_host(data_out_host)
	);

	init_sweep #(
		.index_w(index_w)
	) init_sweep_inst (
		.clk(clk),
		.reset(reset),
		.clear_index(clear_index),
		.clear(clear),
		.sweep_done(sweep_done)
	);

	tag_store #(
		.index_w(index_w)
	) tag_store_inst (
		.clk(clk),
		.index(index),
		.tag(tag),
		.clear(clear),
		.clear_index(clear_index),
		.word_wr(word_wr),
		.fill(fill),
		.hit(hit),
		.dirty(dirty),
		.victim_tag(victim_tag)
	);

	line_store #(
		.index_w(index_w),
		.line_w(line_w)
	) line_store_inst (
		.clk(clk),
		.index(index),
		.word_sel(word_sel),
		.word_wr(word_wr),
		.word_data(word_data),
		.fill(fill),
		.fill_line(fill_line),
		.line_out(line_out),
		.word_out(word_out)
	);

endmodule

// File: sim/mem_system_checker.sv
// Scoreboard for the cache memory system
// Shadows word memory and checks completions, latency and host requests
`timescale 1ns/1ps

module mem_system_checker #(
	parameter int index_w = mem_sys_pkg::index_w,
	parameter int line_w = mem_sys_pkg::line_w
) (
	input logic clk,
	input logic reset,
	input logic en,
	input logic wr,
	input logic [31:0] addr,
	input logic [31:0] data_in,
	input logic [31:0] exp_data,
	input logic exp_hit,
	input logic [31:0] data_out,
	input logic data_valid,
	input logic done,
	input logic cache_hit,
	input mem_sys_pkg::host_op_t op_host,
	input logic [31:0] addr_out_host,
	input logic [line_w-1:0] data_out_host,
	input logic tx_done_host,
	input logic rd_valid_host,
	output int mismatches,
	output int failures
);

	import mem_sys_pkg::*;

	// Sweep of every line plus the step into idle
	localparam int sweep_len = (1 << index_w) + 1;

	logic [31:0] shadow [logic [31:0]];
	logic pending = 1'b0;
	logic seen_done = 1'b0;
	logic answered = 1'b0;
	logic want_hit;
	logic [31:0] want_data;
	logic [31:0] case_data;
	int age;
	int sweep_cycles = 0;
	host_op_t last_op = op_none;
	logic [31:0] last_addr;

	initial begin
		mismatches = 0;
		failures = 0;
	end

	function automatic logic [31:0] shadow_word(input logic [31:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a ^ 32'h5a5a_5a5a;
	endfunction

	task automatic log_mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		mismatches++;
	endtask

	task automatic note_failure(input string msg);
		$display("Error at %0t: %s", $time, msg);
		failures++;
	endtask

	// Victim line must carry every merged word
	task automatic check_writeback;
		int w;
		logic [31:0] a;
		if (addr_out_host % (line_w / 8) != 0) begin
			note_failure("host write address is not line aligned");
		end
		for (w = 0; w < line_w / 32; w++) begin
			a = addr_out_host + 4 * w;
			if (data_out_host[w*32 +: 32] !== shadow_word(a)) begin
				log_mismatch($sformatf("write-back word %h is %h, expected %h",
					a, data_out_host[w*32 +: 32], shadow_word(a)));
			end
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			sweep_cycles <= 0;
		end else begin
			sweep_cycles <= sweep_cycles + 1;
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			if (done && !seen_done) begin
				seen_done = 1'b1;
				if (sweep_cycles != sweep_len) begin
					log_mismatch($sformatf("done rose after %0d cycles, expected %0d",
						sweep_cycles, sweep_len));
				end
			end
			if (done && op_host != op_none) begin
				note_failure("done is high while a host request is open");
			end
			// Host request holds until its answer pulse
			if (last_op != op_none && !answered &&
					(op_host != last_op || addr_out_host != last_addr)) begin
				note_failure("op_host or addr_out_host changed before the host answered");
			end
			if (op_host == op_write && last_op != op_write) begin
				check_writeback();
			end
			last_op = op_host;
			last_addr = addr_out_host;
			answered = tx_done_host || rd_valid_host;

			if (pending) begin
				age++;
			end
			if (data_valid) begin
				if (!pending) begin
					note_failure("data_valid arrived with no accepted access");
				end else begin
					if (data_out !== want_data) begin
						log_mismatch($sformatf("data_out %h, shadow expects %h", data_out, want_data));
					end
					if (data_out !== case_data) begin
						log_mismatch($sformatf("data_out %h, case expects %h", data_out, case_data));
					end
					if (cache_hit !== want_hit) begin
						log_mismatch($sformatf("cache_hit %b, expected %b", cache_hit, want_hit));
					end
					// Hit is lookup then finish
					if (want_hit && age != 2) begin
						log_mismatch($sformatf("hit latency %0d cycles, expected 2", age));
					end else if (!want_hit && age <= 2) begin
						log_mismatch($sformatf("miss completed in %0d cycles", age));
					end
					pending = 1'b0;
				end
			end else if (done && pending) begin
				note_failure("done returned high without data_valid");
				pending = 1'b0;
			end

			if (done && en) begin
				want_hit = exp_hit;
				case_data = exp_data;
				if (wr) begin
					shadow[addr] = data_in;
					want_data = data_in;
				end else begin
					want_data = shadow_word(addr);
				end
				pending = 1'b1;
				age = 0;
			end
		end
	end

endmodule

// File: sim/mem_system_tb.sv
// Testbench for the cache memory system
// Replays the case file and models a host memory with random answer delay
`timescale 1ns/1ps

module mem_system_tb;

	import mem_sys_pkg::*;

	localparam int index_w = 8;
	localparam int line_w = 512;
	localparam int timeout = 1000;
	localparam int max_cases = 64;

	logic clk;
	logic reset;
	logic en;
	logic wr;
	logic [31:0] addr;
	logic [31:0] data_in;
	logic [31:0] data_out;
	logic data_valid;
	logic done;
	logic cache_hit;
	logic [line_w-1:0] data_in_host = '0;
	logic tx_done_host = 1'b0;
	logic rd_valid_host = 1'b0;
	logic [line_w-1:0] data_out_host;
	logic [31:0] addr_out_host;
	host_op_t op_host;

	// Case expectations handed to the checker
	logic [31:0] exp_data;
	logic exp_hit;
	int mismatches;
	int failures;

	// Row layout wr, addr, data_in, expected data, expected hit
	logic [103:0] cases [max_cases];

	// Host memory model
	logic [line_w-1:0] host_mem [logic [31:0]];
	logic [31:0] rng_state = 32'hebe6_cbe3;
	logic host_busy = 1'b0;
	logic holdoff = 1'b0;
	int delay_left = 0;

	mem_system #(
		.index_w(index_w),
		.line_w(line_w)
	) mem_system_inst (
		.clk(clk),
		.reset(reset),
		.en(en),
		.wr(wr),
		.addr(addr),
		.data_in(data_in),
		.data_out(data_out),
		.data_valid(data_valid),
		.done(done),
		.data_in_host(data_in_host),
		.tx_done_host(tx_done_host),
		.rd_valid_host(rd_valid_host),
		.data_out_host(data_out_host),
		.addr_out_host(addr_out_host),
		.op_host(op_host),
		.cache_hit(cache_hit)
	);

	mem_system_checker #(
		.index_w(index_w),
		.line_w(line_w)
	) checker_inst (
		.clk(clk),
		.reset(reset),
		.en(en),
		.wr(wr),
		.addr(addr),
		.data_in(data_in),
		.exp_data(exp_data),
		.exp_hit(exp_hit),
		.data_out(data_out),
		.data_valid(data_valid),
		.done(done),
		.cache_hit(cache_hit),
		.op_host(op_host),
		.addr_out_host(addr_out_host),
		.data_out_host(data_out_host),
		.tx_done_host(tx_done_host),
		.rd_valid_host(rd_valid_host),
		.mismatches(mismatches),
		.failures(failures)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	// Unwritten lines hold address xor pattern
	function automatic logic [line_w-1:0] host_line(input logic [31:0] base);
		logic [line_w-1:0] line;
		if (host_mem.exists(base)) begin
			return host_mem[base];
		end
		for (int w = 0; w < line_w / 32; w++) begin
			line[w*32 +: 32] = (base + 4 * w) ^ 32'h5a5a_5a5a;
		end
		return line;
	endfunction

	always @(posedge clk) begin : host_model
		logic [31:0] r;
		rd_valid_host <= 1'b0;
		tx_done_host <= 1'b0;
		if (reset) begin
			host_busy <= 1'b0;
			holdoff <= 1'b0;
		end else if (holdoff) begin
			// Controller leaves the request state on this edge
			holdoff <= 1'b0;
		end else if (!host_busy && op_host != op_none) begin
			r = xorshift(rng_state);
			rng_state <= r;
			delay_left <= r[2:0] + 1;
			host_busy <= 1'b1;
		end else if (host_busy) begin
			if (delay_left > 1) begin
				delay_left <= delay_left - 1;
			end else begin
				host_busy <= 1'b0;
				holdoff <= 1'b1;
				if (op_host == op_write) begin
					host_mem[addr_out_host] = data_out_host;
					tx_done_host <= 1'b1;
				end else begin
					data_in_host <= host_line(addr_out_host);
					rd_valid_host <= 1'b1;
				end
			end
		end
	end

	// Pokes en while the host is busy to show that the controller drops it
	task automatic wait_for_done(output bit ok);
		int cycles;
		bit busy;
		cycles = 0;
		ok = 1'b1;
		@(negedge clk);
		while (!done && ok) begin
			busy = (op_host != op_none);
			@(posedge clk);
			en <= busy;
			if (busy) begin
				wr <= 1'b1;
				addr <= 32'h0000_0040;
				data_in <= 32'hffff_ffff;
			end
			@(negedge clk);
			cycles++;
			if (cycles == timeout) begin
				$display("Timed out after %0d cycles waiting for done", timeout);
				ok = 1'b0;
			end
		end
	endtask

	task automatic run_case(input logic [103:0] row);
		@(posedge clk);
		en <= 1'b1;
		wr <= row[100];
		addr <= row[99:68];
		data_in <= row[67:36];
		exp_data <= row[35:4];
		exp_hit <= row[0];
		@(posedge clk);
		en <= 1'b0;
	endtask

	task automatic finish_run(input bit ok);
		int other;
		@(posedge clk);
		other = failures + (ok ? 0 : 1);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, other);
		if (mismatches == 0 && other == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	initial begin
		int n;
		bit ok;
		clk = 1'b0;
		reset = 1'b1;
		en = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		exp_data = '0;
		exp_hit = 1'b0;
		// Rows past the end of the file keep the all-ones fill
		for (int i = 0; i < max_cases; i++) begin
			cases[i] = '1;
		end
		$readmemh("sim/mem_cases.txt", cases);
		n = 0;
		while (n < max_cases && cases[n] !== '1) begin
			n++;
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		wait_for_done(ok);
		for (int i = 0; i < n && ok; i++) begin
			run_case(cases[i]);
			wait_for_done(ok);
		end
		finish_run(ok);
	end

endmodule

// File: build.f
rtl/mem_sys_pkg.sv
rtl/init_sweep.sv
rtl/tag_store.sv
rtl/line_store.sv
rtl/cache_ctrl.sv
rtl/mem_system.sv
sim/mem_system_checker.sv
sim/mem_system_tb.sv

// File: sim/mem_cases.txt
// wr_addr_datain_expected_hit, one access per row
// reads carry zero data, writes expect their own data back
0_00000100_00000000_5a5a5b5a_0
0_00000104_00000000_5a5a5b5e_1
0_00000100_00000000_5a5a5b5a_1
1_00000288_cafef00d_cafef00d_0
0_00000288_00000000_cafef00d_1
0_0000028c_00000000_5a5a58d6_1
1_00000284_12345678_12345678_1
// same index, new tag, dirty victim goes back first
0_00004288_00000000_5a5a18d2_0
0_00000288_00000000_cafef00d_0
0_00000284_00000000_12345678_1
1_0003c000_0badf00d_0badf00d_0
0_00000000_00000000_5a5a5a5a_0
0_0003c000_00000000_0badf00d_0
0_0003c03c_00000000_5a599a66_1
// last index
0_00003fc0_00000000_5a5a659a_0
0_00003ffc_00000000_5a5a65a6_1
